// File: hw/paint_cfg.svh
// ------------------------------------------------
// raster, pixel scaling and framebuffer word geometry
// ------------------------------------------------
`ifndef PAINT_CFG_SVH
`define PAINT_CFG_SVH

`default_nettype none

// horizontal raster, in clocks
`define H_ACTIVE      64
`define H_TOTAL       80
`define H_SYNC_START  68
`define H_SYNC_LEN    6

// vertical raster, in lines
`define V_ACTIVE      48
`define V_TOTAL       52
`define V_SYNC_START  49
`define V_SYNC_LEN    2

`define PIX_SCALE     2   // screen pixels per logical pixel, both axes
`define WORD_BITS     6   // logical pixels per ram word, stacked in y
`define RAM_COLS      32  // H_ACTIVE / PIX_SCALE

`define RAM_DEPTH     128 // 4 word rows of RAM_COLS words
`define X_WIDTH       7
`define Y_WIDTH       6
`define ADDR_WIDTH    7
`define SEL_WIDTH     3   // bit select inside a word

`default_nettype wire

`endif

// File: hw/paint_pkg.sv
// ------------------------------------------------
// shared structs and enums of the paint display
// ------------------------------------------------
`include "paint_cfg.svh"
`default_nettype none

package paint_pkg;

  typedef logic [`WORD_BITS-1:0] word_t;  // one framebuffer word

  // raster position with its decoded flags
  typedef struct packed {
    logic [`X_WIDTH-1:0] x;
    logic [`Y_WIDTH-1:0] y;
    logic                active;  // inside the visible area
    logic                hsync;
    logic                vsync;
  } scan_pos_t;

  // brush command in screen coordinates
  typedef struct packed {
    logic [`X_WIDTH-1:0] x;
    logic [`Y_WIDTH-1:0] y;
    logic                ink;     // value written to the pixel
  } paint_cmd_t;

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic active;
    logic pixel;
  } video_out_t;

  // single port request to the framebuffer
  typedef struct packed {
    logic [`ADDR_WIDTH-1:0] addr;
    logic                   we;
    word_t                  wdata;
  } ram_req_t;

  typedef enum logic [1:0] {MEM_DISPLAY, MEM_READ, MEM_WRITE} mem_op_t;

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_WAIT, SEQ_READ, SEQ_WRITE} seq_state_t;

endpackage

`default_nettype wire

// File: hw/scan_timer.sv
// ------------------------------------------------
// raster scan timer, one screen pixel per clock
// ------------------------------------------------
`timescale 1ns/100ps
`include "paint_cfg.svh"
`default_nettype none

module scan_timer (
  input  logic                 clk,
  input  logic                 reset,
  output paint_pkg::scan_pos_t pos,
  output logic                 mem_free   // port slot free for the sequencer
);
  import paint_pkg::*;

  logic [`X_WIDTH-1:0] hpos, hpos_nxt, hpos_nx2;
  logic [`Y_WIDTH-1:0] vpos, vpos_nxt, vpos_nx2;

  // one raster step, wraps line and frame
  function automatic logic [`Y_WIDTH+`X_WIDTH-1:0] advance(
    input logic [`X_WIDTH-1:0] h,
    input logic [`Y_WIDTH-1:0] v
  );
    logic [`X_WIDTH-1:0] h_n;
    logic [`Y_WIDTH-1:0] v_n;
    h_n = h + 1'b1;
    v_n = v;
    if (h == `H_TOTAL-1) begin
      h_n = '0;
      v_n = (v == `V_TOTAL-1) ? '0 : v + 1'b1;  // next line or back to top
    end
    return {v_n, h_n};
  endfunction

  function automatic logic visible(
    input logic [`X_WIDTH-1:0] h,
    input logic [`Y_WIDTH-1:0] v
  );
    return (h < `H_ACTIVE) && (v < `V_ACTIVE);
  endfunction

  assign {vpos_nxt, hpos_nxt} = advance(hpos, vpos);
  assign {vpos_nx2, hpos_nx2} = advance(hpos_nxt, vpos_nxt);  // two steps ahead

  always_ff @(posedge clk) begin
    if (reset) begin
      hpos <= '0;
      vpos <= '0;
    end else begin
      hpos <= hpos_nxt;
      vpos <= vpos_nxt;
    end
  end

  always_comb begin
    pos.x      = hpos;
    pos.y      = vpos;
    pos.active = visible(hpos, vpos);
    pos.hsync  = (hpos >= `H_SYNC_START) && (hpos < `H_SYNC_START + `H_SYNC_LEN);
    pos.vsync  = (vpos >= `V_SYNC_START) && (vpos < `V_SYNC_START + `V_SYNC_LEN);
  end

  // the sequencer reads and writes in the two cycles after it sees this,
  // so neither of those positions may be a visible pixel
  assign mem_free = !visible(hpos_nxt, vpos_nxt) && !visible(hpos_nx2, vpos_nx2);

endmodule

`default_nettype wire

// File: hw/brush_sequencer.sv
// ------------------------------------------------
// brush command FSM, schedules read-modify-write slots
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module brush_sequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  paint,     // one cycle command strobe
  input  paint_pkg::paint_cmd_t brush,
  input  logic                  in_range,  // from the codec, valid with paint
  input  logic                  mem_free,
  output paint_pkg::paint_cmd_t cmd,       // latched command
  output paint_pkg::mem_op_t    mem_op,
  output logic                  busy
);
  import paint_pkg::*;

  seq_state_t state, state_nxt;
  logic       accept;

  // strobes during busy are dropped, out of range ones too
  assign accept = (state == SEQ_IDLE) && paint && in_range;

  always_comb begin
    state_nxt = state;
    case (state)
      SEQ_IDLE: begin
        if (accept) state_nxt = SEQ_WAIT;
      end
      SEQ_WAIT: begin
        if (mem_free) state_nxt = SEQ_READ;  // wait for a blanking slot
      end
      SEQ_READ: begin
        state_nxt = SEQ_WRITE;  // rdata arrives in the write cycle
      end
      SEQ_WRITE: begin
        state_nxt = SEQ_IDLE;
      end
      default: begin
        state_nxt = SEQ_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= SEQ_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // command register, held until the write is done
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd <= brush;
    end
  end

  // port opcode for the codec
  always_comb begin
    case (state)
      SEQ_READ:  mem_op = MEM_READ;
      SEQ_WRITE: mem_op = MEM_WRITE;
      default:   mem_op = MEM_DISPLAY;  // display owns the port otherwise
    endcase
  end

  assign busy = (state != SEQ_IDLE);  // falls the cycle after SEQ_WRITE

endmodule

`default_nettype wire

// File: hw/pixel_mem_codec.sv
// ------------------------------------------------
// framebuffer address coding, pixel extraction and merge
// ------------------------------------------------
`timescale 1ns/100ps
`include "paint_cfg.svh"
`default_nettype none

module pixel_mem_codec (
  input  logic                  clk,
  input  logic                  reset,
  input  paint_pkg::scan_pos_t  pos,
  input  paint_pkg::paint_cmd_t brush,     // raw command, range check only
  input  paint_pkg::paint_cmd_t cmd,       // latched command
  input  paint_pkg::mem_op_t    mem_op,
  input  paint_pkg::word_t      rdata,
  output logic                  in_range,
  output paint_pkg::ram_req_t   req,
  output paint_pkg::video_out_t video
);
  import paint_pkg::*;

  logic [`X_WIDTH-1:0]   src_x;
  logic [`Y_WIDTH-1:0]   src_y;
  logic [`SEL_WIDTH-1:0] cmd_sel;
  logic [`SEL_WIDTH-1:0] disp_sel;
  logic [`SEL_WIDTH-1:0] sel_d1;    // display bit select, aligned with rdata
  logic                  active_d1;
  logic                  hsync_d1;
  logic                  vsync_d1;
  word_t                 merged;

  // words run along x, word rows cover WORD_BITS logical lines
  function automatic logic [`ADDR_WIDTH-1:0] word_addr(
    input logic [`X_WIDTH-1:0] x,
    input logic [`Y_WIDTH-1:0] y
  );
    int unsigned ly;
    int unsigned a;
    ly = y / `PIX_SCALE;
    a  = (ly / `WORD_BITS) * `RAM_COLS + x / `PIX_SCALE;
    return a[`ADDR_WIDTH-1:0];  // blanking positions may wrap, never shown
  endfunction

  function automatic logic [`SEL_WIDTH-1:0] bit_sel(input logic [`Y_WIDTH-1:0] y);
    int unsigned s;
    s = (y / `PIX_SCALE) % `WORD_BITS;
    return s[`SEL_WIDTH-1:0];
  endfunction

  assign in_range = (brush.x < `H_ACTIVE) && (brush.y < `V_ACTIVE);

  assign src_x    = (mem_op == MEM_DISPLAY) ? pos.x : cmd.x;
  assign src_y    = (mem_op == MEM_DISPLAY) ? pos.y : cmd.y;
  assign cmd_sel  = bit_sel(cmd.y);
  assign disp_sel = bit_sel(pos.y);

  // replace one bit, keep the neighbours read the cycle before
  always_comb begin
    merged          = rdata;
    merged[cmd_sel] = cmd.ink;
  end

  always_comb begin
    req.addr  = word_addr(src_x, src_y);
    req.we    = (mem_op == MEM_WRITE);
    req.wdata = merged;
  end

  always_ff @(posedge clk) begin
    sel_d1 <= disp_sel;
  end

  // stage 1 waits for the ram, stage 2 is the output register
  always_ff @(posedge clk) begin
    if (reset) begin
      active_d1 <= 1'b0;
      hsync_d1  <= 1'b0;
      vsync_d1  <= 1'b0;
      video     <= '0;
    end else begin
      active_d1    <= pos.active;
      hsync_d1     <= pos.hsync;
      vsync_d1     <= pos.vsync;
      video.hsync  <= hsync_d1;
      video.vsync  <= vsync_d1;
      video.active <= active_d1;
      video.pixel  <= active_d1 & rdata[sel_d1];  // black in blanking
    end
  end

endmodule

`default_nettype wire

// File: hw/frame_ram.sv
// ------------------------------------------------
// single port framebuffer, synchronous read
// ------------------------------------------------
`timescale 1ns/100ps
`include "paint_cfg.svh"
`default_nettype none

module frame_ram (
  input  logic                clk,
  input  paint_pkg::ram_req_t req,
  output paint_pkg::word_t    rdata  // one cycle after the address
);
  import paint_pkg::*;

  word_t mem [`RAM_DEPTH] = '{default: '0};  // blank picture at start

  always_ff @(posedge clk) begin
    if (req.we) begin
      mem[req.addr] <= req.wdata;
    end
    rdata <= mem[req.addr];  // old data on a write cycle
  end

endmodule

`default_nettype wire

// File: hw/paint_display_top.sv
// ------------------------------------------------
// paint display top, timer, brush FSM, codec and ram
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module paint_display_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  paint,
  input  paint_pkg::paint_cmd_t brush,
  output paint_pkg::video_out_t video,
  output logic                  busy
);
  import paint_pkg::*;

  scan_pos_t  pos;
  logic       mem_free;
  logic       in_range;
  paint_cmd_t cmd;
  mem_op_t    mem_op;
  ram_req_t   req;
  word_t      rdata;

  scan_timer i_scan_timer (
    .clk      (clk),
    .reset    (reset),
    .pos      (pos),
    .mem_free (mem_free)
  );

  brush_sequencer i_brush_sequencer (
    .clk      (clk),
    .reset    (reset),
    .paint    (paint),
    .brush    (brush),
    .in_range (in_range),
    .mem_free (mem_free),
    .cmd      (cmd),
    .mem_op   (mem_op),
    .busy     (busy)
  );

  pixel_mem_codec i_pixel_mem_codec (
    .clk      (clk),
    .reset    (reset),
    .pos      (pos),
    .brush    (brush),
    .cmd      (cmd),
    .mem_op   (mem_op),
    .rdata    (rdata),
    .in_range (in_range),
    .req      (req),
    .video    (video)
  );

  frame_ram i_frame_ram (
    .clk   (clk),
    .req   (req),
    .rdata (rdata)
  );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
// ------------------------------------------------
// testbench clock, 8 ns period, 2 cycle reset
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int half_period = 4
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;  // released 1 ns after the second edge
  end

endmodule

`default_nettype wire

// File: tests/paint_display_properties.sv
// ------------------------------------------------
// bound checks on the brush FSM and the ram port
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module paint_display_properties (
  input logic                 clk,
  input logic                 reset,
  input logic                 busy,
  input paint_pkg::mem_op_t   mem_op,
  input paint_pkg::ram_req_t  req,
  input paint_pkg::scan_pos_t pos
);
  import paint_pkg::*;

  int unsigned failures = 0;  // assertion failures so far

  // sync reset leaves the FSM idle
  idle_after_reset: assert property (@(posedge clk) reset |=> !busy)
    else begin
      failures++;
      $error("busy high in the cycle after reset");
    end

  // MEM_READ only comes from SEQ_READ, MEM_WRITE only from SEQ_WRITE
  read_then_write: assert property (@(posedge clk) disable iff (reset)
    mem_op == MEM_READ |=> mem_op == MEM_WRITE)
    else begin
      failures++;
      $error("read slot not followed by a write slot");
    end

  // a write lands on the word read in the slot before it
  write_only_in_write_slot: assert property (@(posedge clk) disable iff (reset)
    req.we |-> mem_op == MEM_WRITE && $past(mem_op) == MEM_READ
               && req.addr == $past(req.addr))
    else begin
      failures++;
      $error("ram write outside the write slot or to another word");
    end

  // brush traffic must stay out of visible pixels
  no_access_while_active: assert property (@(posedge clk) disable iff (reset)
    mem_op != MEM_DISPLAY |-> !pos.active)
    else begin
      failures++;
      $error("brush access during an active pixel");
    end

endmodule

bind paint_display_top paint_display_properties i_properties (
  .clk    (clk),
  .reset  (reset),
  .busy   (busy),
  .mem_op (mem_op),
  .req    (req),
  .pos    (pos)
);

`default_nettype wire

// File: tests/paint_display_tb.sv
// ------------------------------------------------
// paint display testbench, table driven paints and frame compares
// ------------------------------------------------
`timescale 1ns/100ps
`include "paint_cfg.svh"
`default_nettype none

module paint_display_tb;
  import paint_pkg::*;

  localparam int busy_timeout  = 200;
  localparam int frame_timeout = 2 * `H_TOTAL * `V_TOTAL;  // two frames

  typedef struct packed {
    logic [3:0] test_no;
    logic [6:0] x;
    logic [5:0] y;
    logic       ink;
    logic       accept;   // strobe should start a write
    logic       overlap;  // second strobe while busy
    logic [6:0] x2;
    logic [5:0] y2;
  } entry_t;

  logic       clk;
  logic       reset;
  logic       paint;
  logic       busy;
  paint_cmd_t brush;
  video_out_t video;
  entry_t     stim [$];
  logic       model [`RAM_COLS][`V_ACTIVE/`PIX_SCALE];  // logical pixels
  int         seed = 32'he447_0c01;
  int         n_pass = 0;
  int         n_fail = 0;

  tb_clock_gen i_tb_clock_gen (.clk(clk), .reset(reset));

  paint_display_top i_paint_display_top (
    .clk   (clk),
    .reset (reset),
    .paint (paint),
    .brush (brush),
    .video (video),
    .busy  (busy)
  );

  function automatic void add_entry(input int test_no, input int x, input int y,
                                    input logic ink, input logic accept,
                                    input logic overlap, input int x2, input int y2);
    entry_t e;
    e = '{test_no: test_no, x: x, y: y, ink: ink, accept: accept,
          overlap: overlap, x2: x2, y2: y2};
    stim.push_back(e);
  endfunction

  task automatic end_run();
    int prop_fails;
    prop_fails = i_paint_display_top.i_properties.failures;
    $display("%0d tests passed, %0d failed, %0d assertion failures",
             n_pass, n_fail, prop_fails);
    if (n_fail == 0 && prop_fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic abort_run(input string what);
    $display("timeout, %s", what);
    n_fail++;
    end_run();
  endtask

  task automatic report(input int test_no, input string what, input int errs);
    if (errs == 0) begin
      n_pass++;
      $display("test %0d %s: ok", test_no, what);
    end else begin
      n_fail++;
      $display("test %0d %s: %0d errors", test_no, what, errs);
    end
  endtask

  task automatic wait_idle();
    int cyc;
    cyc = 0;
    while (busy) begin
      @(posedge clk);
      #1;
      cyc++;
      if (cyc > busy_timeout) abort_run("busy did not fall within 200 cycles");
    end
  endtask

  // next full frame from the rise of vsync, screen pixel against model
  task automatic check_frame(output int errs);
    int         cyc;
    int         n;
    int         sx;
    int         sy;
    int         rx;
    int         ry;
    logic       expect_pix;
    logic [2:0] expect_flags;  // hsync, vsync, active
    errs = 0;
    cyc  = 0;
    n    = 0;
    @(negedge clk);
    while (video.vsync) begin
      @(negedge clk);
      cyc++;
      if (cyc > frame_timeout) abort_run("vsync stayed high");
    end
    while (!video.vsync) begin
      @(negedge clk);
      cyc++;
      if (cyc > frame_timeout) abort_run("no vsync within two frames");
    end
    rx = 0;
    ry = `V_SYNC_START;  // vsync rises with the first pixel of its line
    while (n < `H_ACTIVE * `V_ACTIVE) begin
      @(negedge clk);
      cyc++;
      if (cyc > frame_timeout) abort_run("frame not complete within two frames");
      rx++;
      if (rx == `H_TOTAL) begin
        rx = 0;
        ry = (ry == `V_TOTAL - 1) ? 0 : ry + 1;
      end
      expect_flags = {(rx >= `H_SYNC_START) && (rx < `H_SYNC_START + `H_SYNC_LEN),
                      (ry >= `V_SYNC_START) && (ry < `V_SYNC_START + `V_SYNC_LEN),
                      (rx < `H_ACTIVE) && (ry < `V_ACTIVE)};
      if ({video.hsync, video.vsync, video.active} !== expect_flags) begin
        if (errs < 4) $display("FAILED video.hsync,vsync,active at x=%0d y=%0d: got %h expected %h",
                               rx, ry, {video.hsync, video.vsync, video.active},
                               expect_flags);
        errs++;
      end
      if (video.active) begin
        sx = n % `H_ACTIVE;
        sy = n / `H_ACTIVE;
        expect_pix = model[sx / `PIX_SCALE][sy / `PIX_SCALE];
        if (video.pixel !== expect_pix) begin
          if (errs < 4) $display("FAILED video.pixel at x=%0d y=%0d: got %h expected %h",
                                 sx, sy, video.pixel, expect_pix);
          errs++;
        end
        n++;
      end
    end
  endtask

  task automatic apply_entry(input entry_t e, output int errs);
    int frame_errs;
    int cyc;
    errs = 0;
    @(posedge clk);
    #1;
    paint = 1'b1;
    brush = '{x: e.x, y: e.y, ink: e.ink};
    @(posedge clk);
    #1;
    if (e.overlap) brush = '{x: e.x2, y: e.y2, ink: 1'b1};  // strobe held into busy
    else paint = 1'b0;
    if (busy !== e.accept) begin
      $display("FAILED busy after strobe: got %h expected %h", busy, e.accept);
      errs++;
    end
    if (e.overlap) begin
      @(posedge clk);
      #1;
      paint = 1'b0;
    end
    if (e.accept) begin
      model[e.x / `PIX_SCALE][e.y / `PIX_SCALE] = e.ink;  // first command only
      wait_idle();
    end else begin
      for (cyc = 0; cyc < 10; cyc++) begin
        @(posedge clk);
        #1;
        if (busy !== 1'b0) begin
          $display("FAILED busy on dropped command: got %h expected %h", busy, 1'b0);
          errs++;
        end
      end
    end
    check_frame(frame_errs);
    errs += frame_errs;
  endtask

  initial begin
    int errs;
    int cyc;
    int r;
    paint = 1'b0;
    brush = '0;
    foreach (model[i, j]) model[i][j] = 1'b0;

    add_entry(2, 10, 7, 1'b1, 1'b1, 1'b0, 0, 0);
    r = $random(seed);
    add_entry(2, r[5:0], $unsigned(r[15:8]) % `V_ACTIVE, 1'b1, 1'b1, 1'b0, 0, 0);
    r = $random(seed);
    add_entry(2, r[5:0], $unsigned(r[15:8]) % `V_ACTIVE, 1'b1, 1'b1, 1'b0, 0, 0);
    add_entry(3, 20, 24, 1'b1, 1'b1, 1'b0, 0, 0);   // logical row 12
    add_entry(3, 21, 26, 1'b1, 1'b1, 1'b0, 0, 0);   // row 13, same word
    add_entry(4, 20, 24, 1'b0, 1'b1, 1'b0, 0, 0);
    add_entry(5, 64, 5, 1'b1, 1'b0, 1'b0, 0, 0);
    add_entry(5, 3, 48, 1'b1, 1'b0, 1'b0, 0, 0);
    add_entry(5, 127, 63, 1'b1, 1'b0, 1'b0, 0, 0);
    add_entry(6, 40, 30, 1'b1, 1'b1, 1'b1, 50, 40);

    errs = 0;
    cyc  = 0;
    while (reset !== 1'b0) begin
      @(posedge clk);
      cyc++;
      if (cyc > 10) abort_run("reset never released");
    end
    #1;
    if ({busy, video.hsync, video.vsync, video.active} !== 4'h0) begin
      $display("FAILED busy,hsync,vsync,active after reset: got %h expected %h",
               {busy, video.hsync, video.vsync, video.active}, 4'h0);
      errs++;
    end
    check_frame(r);
    report(1, "reset and blank frame", errs + r);

    foreach (stim[k]) begin
      apply_entry(stim[k], errs);
      report(stim[k].test_no, $sformatf("entry %0d x=%0d y=%0d ink=%0d", k,
             stim[k].x, stim[k].y, stim[k].ink), errs);
    end
    end_run();
  end

endmodule

`default_nettype wire

// File: paint_display_top.f
+incdir+hw
hw/paint_pkg.sv
hw/scan_timer.sv
hw/brush_sequencer.sv
hw/pixel_mem_codec.sv
hw/frame_ram.sv
hw/paint_display_top.sv
tests/tb_clock_gen.sv
tests/paint_display_properties.sv
tests/paint_display_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = paint_display_tb
FILELIST = paint_display_top.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
